// File: byte_fifo.sv
// Circular FIFO with a four-phase req/ack link on each side.
`timescale 1ns/100ps

module byte_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic   clk,
    input  logic   arst_n,
    hs_link_if.dst in,
    hs_link_if.src out
);

    localparam int AW = $clog2(DEPTH);

    T            mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;    // One extra bit tells full from empty.
    logic          full;
    logic          push;
    logic          pop;

    assign full = (count == (AW + 1)'(DEPTH));
    assign push = in.req && !in.ack && !full;   // Full withholds ack as back-pressure.
    assign pop  = out.req && out.ack;           // Head leaves once the consumer acks.

    // Acceptor and offerer run side by side.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            in.ack  <= 1'b0;
            out.req <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;            // Pointers wrap on their own.
                in.ack <= 1'b1;
            end else if (in.ack && !in.req) begin
                in.ack <= 1'b0;                     // Producer released req.
            end

            if (pop) begin
                rd_ptr  <= rd_ptr + 1'b1;
                out.req <= 1'b0;
            end else if (!out.req && !out.ack && count != '0) begin
                out.req <= 1'b1;                    // Offer the head entry.
            end

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in.payload;
        end
    end

    // The head entry is not overwritten while it is offered.
    assign out.payload = mem[rd_ptr];

endmodule

// File: cmd_exec.sv
// Command executor that drives the LED and replies to every byte over the UART.
`timescale 1ns/100ps
`include "uart_cfg.svh"

module cmd_exec (
    input  logic   clk,
    input  logic   arst_n,
    hs_link_if.dst in,
    output logic   tx,
    output logic   tx_busy,
    output logic   led
);
    import uart_pkg::*;

    rx_byte_t   cmd;
    logic [7:0] reply;     // Reply for the offered byte.
    logic [7:0] reply_q;   // Reply handed to the transmitter.
    logic       led_next;
    logic       tx_start;  // One-cycle strobe, also marks a pending reply.
    logic       accept;

    assign cmd    = in.payload;
    assign accept = in.req && !in.ack && !tx_busy && !tx_start; // Wait for a free transmitter.

    always_comb begin
        led_next = led;
        reply    = `REPLY_NAK;                   // Bad bytes and unknown codes.
        if (!cmd.bad) begin
            case (cmd.data)
                `CMD_LED_ON: begin
                    led_next = 1'b1;
                    reply    = `CMD_LED_ON;
                end
                `CMD_LED_OFF: begin
                    led_next = 1'b0;
                    reply    = `CMD_LED_OFF;
                end
                `CMD_LED_TOGGLE: begin
                    led_next = ~led;
                    reply    = `CMD_LED_TOGGLE;
                end
                default: reply = `REPLY_NAK;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in.ack   <= 1'b0;
            led      <= 1'b0;
            tx_start <= 1'b0;
        end else begin
            tx_start <= accept;
            if (accept) begin
                in.ack <= 1'b1;
                led    <= led_next;              // LED moves on the ack edge.
            end else if (in.ack && !in.req) begin
                in.ack <= 1'b0;                  // Handshake closes.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            reply_q <= reply;
        end
    end

    uart_tx u_tx (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (tx_start),
        .data   (reply_q),
        .tx     (tx),
        .busy   (tx_busy)
    );

endmodule

// File: hs_link_if.sv
// Four-phase req/ack link that carries one payload of a chosen type.
`timescale 1ns/100ps

interface hs_link_if #(
    parameter type T = logic [7:0]
);

    logic req;     // Raised by the producer while the payload is offered.
    logic ack;     // Raised by the consumer once the payload has been taken.
    T     payload; // Held stable from req rising until ack rises.

    // The producer side drives req and payload.
    modport src (
        output req,
        output payload,
        input  ack
    );

    // The consumer side answers with ack.
    modport dst (
        input  req,
        input  payload,
        output ack
    );

endinterface

// File: run.sh
#!/bin/sh
# Builds the serial LED controller testbench with Verilator and runs it once.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f uart_led_ctrl.f --top-module tb_uart_led_ctrl

sim_out=$(./obj_dir/Vtb_uart_led_ctrl 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "Verification passed"; then
    exit 0
else
    exit 1
fi

// File: tb_clk_gen.sv
// Testbench clock and reset source for a 10 ns clock and a short reset pulse.
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int HALF_PERIOD  = 5,   // Half of the 10 ns clock period.
    parameter int RESET_CYCLES = 2    // Rising edges seen while reset is held.
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;                        // Reset is active from time zero.
        repeat (RESET_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;                     // Released just after an edge like other inputs.
    end

endmodule

// File: tb_uart_led_ctrl.sv
// Testbench top that drives UART commands into the LED controller and checks every reply.
`timescale 1ns/100ps
`include "uart_cfg.svh"

module tb_uart_led_ctrl;

    localparam int CPB          = `UART_CLKS_PER_BIT;
    localparam int FRAME_CYCLES = 11 * CPB;                 // Start, eight data, parity, stop.
    localparam int N_BYTES      = 20;                       // Bytes sent over all tests.
    localparam int TIMEOUT      = N_BYTES * (2 * FRAME_CYCLES + 24) + 2000; // Idle checks included.

    logic       clk;
    logic       arst_n;
    logic       rx;
    logic       tx;
    logic       tx_busy;
    logic       led;
    logic [7:0] exp_reply [$];   // Replies still due, oldest first.
    logic       exp_led   [$];   // LED level expected once each reply starts.
    string      exp_test  [$];
    logic       led_model;
    int         seed;
    int         cycle_cnt = 0;

    tb_clk_gen #(.HALF_PERIOD(5), .RESET_CYCLES(2)) u_clk_gen (.clk(clk), .arst_n(arst_n));

    uart_led_ctrl DUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .rx      (rx),
        .tx      (tx),
        .tx_busy (tx_busy),
        .led     (led)
    );

    bind uart_led_ctrl uart_led_ctrl_asserts u_asserts (
        .clk        (clk),
        .arst_n     (arst_n),
        .tx         (tx),
        .tx_busy    (tx_busy),
        .led        (led),
        .rx_req     (rx_link.req),
        .rx_ack     (rx_link.ack),
        .rx_payload (rx_link.payload),
        .ex_req     (exec_link.req),
        .ex_ack     (exec_link.ack),
        .ex_payload (exec_link.payload)
    );

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    task automatic report_mismatch(input string test, input string what,
                                   input logic [7:0] exp, input logic [7:0] act);
        $display("Mismatch in %s, %s: expected 8'h%02h, actual 8'h%02h", test, what, exp, act);
        abort_run();
    endtask

    task automatic check_bit(input string test, input string what, input logic exp,
                             input logic act);
        assert (act === exp) else report_mismatch(test, what, 8'(exp), 8'(act));
    endtask

    // Known codes echo and move the LED and anything else earns a NAK.
    task automatic queue_reply(input string test, input logic [7:0] data, input logic bad);
        logic [7:0] reply;
        reply = `REPLY_NAK;
        if (!bad && data == `CMD_LED_ON) begin
            led_model = 1'b1;
            reply     = data;
        end else if (!bad && data == `CMD_LED_OFF) begin
            led_model = 1'b0;
            reply     = data;
        end else if (!bad && data == `CMD_LED_TOGGLE) begin
            led_model = !led_model;
            reply     = data;
        end
        exp_reply.push_back(reply);
        exp_led.push_back(led_model);
        exp_test.push_back(test);
    endtask

    // Frame bits go out LSB first with the parity bit optionally inverted.
    task automatic send_frame(input logic [7:0] data, input logic flip_par);
        logic [10:0] bits;
        bits = {1'b1, (^data) ^ flip_par, data, 1'b0};
        repeat (11) begin
            @(posedge clk);
            #1 rx = bits[0];
            bits = bits >> 1;
            repeat (CPB - 1) @(posedge clk);
        end
    endtask

    task automatic send_byte(input string test, input logic [7:0] data, input logic flip_par);
        queue_reply(test, data, flip_par);
        send_frame(data, flip_par);
    endtask

    task automatic wait_replies();
        @(negedge clk);
        while (exp_reply.size() != 0 || tx_busy) @(negedge clk);
    endtask

    task automatic run_single(input string test, input logic [7:0] data, input logic flip_par);
        send_byte(test, data, flip_par);
        wait_replies();
    endtask

    // Deframes every reply from the middle of each bit.
    initial begin : reply_monitor
        logic [7:0] got;
        logic [7:0] want;
        logic       want_led;
        string      test;
        forever begin
            @(negedge clk);
            if (arst_n === 1'b1 && tx_busy === 1'b1) begin
                assert (exp_reply.size() != 0)
                    else report_problem("A reply appeared on tx with no command pending.");
                want     = exp_reply.pop_front();
                want_led = exp_led.pop_front();
                test     = exp_test.pop_front();
                check_bit(test, "led", want_led, led);   // LED moved one edge before tx_busy.
                repeat (CPB / 2) @(negedge clk);
                check_bit(test, "start bit", 1'b0, tx);
                repeat (8) begin
                    repeat (CPB) @(negedge clk);
                    got = {tx, got[7:1]};
                end
                assert (got === want) else report_mismatch(test, "reply", want, got);
                repeat (CPB) @(negedge clk);
                check_bit(test, "parity", $countones(want) % 2 == 1, tx); // Even count of ones.
                repeat (CPB) @(negedge clk);
                check_bit(test, "stop bit", 1'b1, tx);
                check_bit(test, "tx_busy", 1'b1, tx_busy); // Busy lasts through the stop bit.
                while (tx_busy === 1'b1) @(negedge clk);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            report_problem("Timeout: the tests did not finish within the cycle limit.");
        end
        if (DUT.u_asserts.fail_cnt != 0) begin
            report_problem("A protocol assertion on the DUT failed.");
        end
    end

    initial begin : stimulus
        logic [7:0] code;
        int         sent;
        rx        = 1'b1;                      // Idle line level.
        led_model = 1'b0;
        seed      = 32'hc9e5;
        sent      = 0;
        @(posedge arst_n);
        @(negedge clk);
        check_bit("reset", "tx", 1'b1, tx);
        check_bit("reset", "tx_busy", 1'b0, tx_busy);
        check_bit("reset", "led", 1'b0, led);
        repeat (4 * CPB) @(negedge clk);       // Any reply here has no command behind it.

        run_single("commands", `CMD_LED_ON, 1'b0);
        run_single("commands", `CMD_LED_OFF, 1'b0);
        run_single("commands", `CMD_LED_TOGGLE, 1'b0);
        run_single("commands", `CMD_LED_TOGGLE, 1'b0);
        run_single("commands", `CMD_LED_ON, 1'b0);

        run_single("bad_parity", `CMD_LED_OFF, 1'b1);
        run_single("bad_parity", `CMD_LED_TOGGLE, 1'b1);

        while (sent < 8) begin
            code = 8'($random(seed));
            if (code != `CMD_LED_ON && code != `CMD_LED_OFF && code != `CMD_LED_TOGGLE) begin
                run_single("unknown_codes", code, 1'b0);
                sent++;
            end
        end

        // One more frame than the FIFO holds goes out with no idle time in between.
        for (int i = 0; i < `UART_FIFO_DEPTH + 1; i++) begin
            case (i % 3)
                0:       code = `CMD_LED_TOGGLE;
                1:       code = `CMD_LED_OFF;
                default: code = `CMD_LED_ON;
            endcase
            send_byte("burst", code, 1'b0);
        end
        wait_replies();
        check_bit("burst", "final led", led_model, led);

        if (DUT.u_asserts.fail_cnt == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            report_problem("A protocol assertion on the DUT failed.");
        end
    end

endmodule

// File: uart_cfg.svh
// UART link configuration with bit timing, FIFO depth and command and reply codes.
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// Clock cycles spent on each serial bit.
`define UART_CLKS_PER_BIT 8

// Entries in the byte FIFO between receiver and executor. Must be a power of two.
`define UART_FIFO_DEPTH 4

// Command codes understood by the executor.
`define CMD_LED_ON     8'hAA
`define CMD_LED_OFF    8'h55
`define CMD_LED_TOGGLE 8'hC3

// Reply for a corrupted byte or an unknown code.
`define REPLY_NAK      8'h15

`endif

// File: uart_led_ctrl.f
+incdir+.
uart_pkg.sv
hs_link_if.sv
uart_rx.sv
byte_fifo.sv
uart_tx.sv
cmd_exec.sv
uart_led_ctrl.sv
uart_led_ctrl_asserts.sv
tb_clk_gen.sv
tb_uart_led_ctrl.sv

// File: uart_led_ctrl.sv
// Serial LED controller built from receiver, byte FIFO and command executor.
`timescale 1ns/100ps
`include "uart_cfg.svh"

module uart_led_ctrl (
    input  logic clk,
    input  logic arst_n,
    input  logic rx,
    output logic tx,
    output logic tx_busy,
    output logic led
);
    import uart_pkg::*;

    hs_link_if #(.T(rx_byte_t)) rx_link   ();  // Receiver into FIFO.
    hs_link_if #(.T(rx_byte_t)) exec_link ();  // FIFO into executor.

    uart_rx u_rx (
        .clk    (clk),
        .arst_n (arst_n),
        .rx     (rx),
        .out    (rx_link.src)
    );

    byte_fifo #(
        .T     (rx_byte_t),
        .DEPTH (`UART_FIFO_DEPTH)
    ) u_fifo (
        .clk    (clk),
        .arst_n (arst_n),
        .in     (rx_link.dst),
        .out    (exec_link.src)
    );

    cmd_exec u_exec (
        .clk     (clk),
        .arst_n  (arst_n),
        .in      (exec_link.dst),
        .tx      (tx),
        .tx_busy (tx_busy),
        .led     (led)
    );

endmodule

// File: uart_led_ctrl_asserts.sv
// Protocol checks for the serial LED controller, bound into its top level.
`timescale 1ns/100ps

module uart_led_ctrl_asserts (
    input logic               clk,
    input logic               arst_n,
    input logic               tx,
    input logic               tx_busy,
    input logic               led,
    input logic               rx_req,
    input logic               rx_ack,
    input uart_pkg::rx_byte_t rx_payload,
    input logic               ex_req,
    input logic               ex_ack,
    input uart_pkg::rx_byte_t ex_payload
);

    int fail_cnt = 0;   // Failed checks so far, watched by the testbench top.

    // The line must rest high whenever no frame is being sent.
    a_tx_idle: assert property (@(posedge clk) disable iff (!arst_n) !tx_busy |-> tx)
        else begin fail_cnt = fail_cnt + 1; $error("tx is low while tx_busy is low"); end

    // Once offered, a request waits for its acknowledge.
    a_rx_req_held: assert property (@(posedge clk) disable iff (!arst_n)
        rx_req && !rx_ack |=> rx_req)
        else begin fail_cnt = fail_cnt + 1; $error("rx_link req dropped before ack"); end
    a_ex_req_held: assert property (@(posedge clk) disable iff (!arst_n)
        ex_req && !ex_ack |=> ex_req)
        else begin fail_cnt = fail_cnt + 1; $error("exec_link req dropped before ack"); end

    // Payload is frozen for the whole open request.
    a_rx_stable: assert property (@(posedge clk) disable iff (!arst_n)
        rx_req && !rx_ack |=> $stable(rx_payload))
        else begin fail_cnt = fail_cnt + 1; $error("rx_link payload moved during req"); end
    a_ex_stable: assert property (@(posedge clk) disable iff (!arst_n)
        ex_req && !ex_ack |=> $stable(ex_payload))
        else begin fail_cnt = fail_cnt + 1; $error("exec_link payload moved during req"); end

    // Acknowledge is only withdrawn after the request is gone.
    a_rx_ack_fall: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(rx_ack) |-> !$past(rx_req))
        else begin fail_cnt = fail_cnt + 1; $error("rx_link ack fell while req high"); end
    a_ex_ack_fall: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(ex_ack) |-> !$past(ex_req))
        else begin fail_cnt = fail_cnt + 1; $error("exec_link ack fell while req high"); end

    // The LED register only moves when the executor takes a command.
    a_led_on_ack: assert property (@(posedge clk) disable iff (!arst_n)
        (led != $past(led)) |-> $rose(ex_ack))
        else begin fail_cnt = fail_cnt + 1; $error("led changed without an exec_link ack"); end

endmodule

// File: uart_pkg.sv
// Shared types for the serial LED command link.
package uart_pkg;

    // One received byte together with its error flag.
    typedef struct packed {
        logic [7:0] data; // Byte as deframed from the rx line.
        logic       bad;  // Set on a parity or stop bit error.
    } rx_byte_t;

endpackage

// File: uart_rx.sv
// UART receiver that deframes 8E1 bytes, checks them and offers them on a req/ack link.
`timescale 1ns/100ps
`include "uart_cfg.svh"

module uart_rx (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   rx,
    hs_link_if.src out
);
    import uart_pkg::*;

    localparam int CPB = `UART_CLKS_PER_BIT;
    localparam int CW  = $clog2(CPB);
    localparam logic [CW-1:0] CNT_MID  = CW'(CPB / 2 - 1); // Middle of the start bit.
    localparam logic [CW-1:0] CNT_LAST = CW'(CPB - 1);     // One full bit period.

    typedef enum logic [2:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_PARITY,
        S_STOP
    } state_t;

    state_t        state;
    logic [2:0]    rx_sync;   // Two synchronizer stages plus one edge stage.
    logic          rx_bit;
    logic          rx_fell;
    logic [CW-1:0] cnt;       // Cycles within the current bit.
    logic [2:0]    bit_idx;   // Data bit being received.
    logic [7:0]    shreg;     // Data bits arrive LSB first.
    logic          par_bit;
    rx_byte_t      hold;      // Offered byte, kept until the consumer acks.
    logic          bit_tick;
    logic          stop_smp;
    logic          link_free;

    assign rx_bit    = rx_sync[1];                 // Synchronized line level.
    assign rx_fell   = rx_sync[2] & ~rx_sync[1];   // Falling edge opens a frame.
    assign bit_tick  = (cnt == CNT_LAST);          // Middle of a data, parity or stop bit.
    assign stop_smp  = (state == S_STOP) && bit_tick;
    assign link_free = !out.req && !out.ack;       // Previous handshake fully closed.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_sync <= '1;                         // Idle line is high.
            state   <= S_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            out.req <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[1:0], rx};
            case (state)
                S_IDLE: begin
                    cnt <= '0;
                    if (rx_fell) begin
                        state <= S_START;
                    end
                end
                S_START: begin
                    if (cnt == CNT_MID) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_bit ? S_IDLE : S_DATA; // A glitch returns to idle.
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_DATA: begin
                    if (bit_tick) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= S_PARITY;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_PARITY: begin
                    if (bit_tick) begin
                        cnt   <= '0;
                        state <= S_STOP;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_STOP: begin
                    if (bit_tick) begin
                        cnt   <= '0;
                        state <= S_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase

            // A frame that ends while the link is busy is lost.
            if (stop_smp && link_free) begin
                out.req <= 1'b1;
            end else if (out.req && out.ack) begin
                out.req <= 1'b0;                   // Consumer has the byte.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_DATA && bit_tick) begin
            shreg <= {rx_bit, shreg[7:1]};
        end
        if (state == S_PARITY && bit_tick) begin
            par_bit <= rx_bit;
        end
        if (stop_smp && link_free) begin
            hold.data <= shreg;
            hold.bad  <= (^{shreg, par_bit}) | ~rx_bit; // Odd count or low stop bit.
        end
    end

    assign out.payload = hold;

endmodule

// File: uart_tx.sv
// UART transmitter that sends one byte as an 8E1 frame.
`timescale 1ns/100ps
`include "uart_cfg.svh"

module uart_tx (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       start,
    input  logic [7:0] data,
    output logic       tx,
    output logic       busy
);

    localparam int CPB = `UART_CLKS_PER_BIT;
    localparam int CW  = $clog2(CPB);
    localparam logic [CW-1:0] CNT_LAST = CW'(CPB - 1);
    localparam logic [3:0]    IDX_STOP = 4'd10; // Start, eight data, parity, stop.

    logic [CW-1:0] cnt;       // Cycles within the current bit.
    logic [3:0]    bit_idx;   // Bit now on the line.
    logic [3:0]    next_idx;
    logic          next_bit;
    logic [7:0]    data_q;
    logic          par_q;

    assign next_idx = bit_idx + 4'd1;

    // Level of the bit that follows the current one.
    always_comb begin
        case (next_idx)
            4'd9:    next_bit = par_q;
            4'd10:   next_bit = 1'b1;
            default: next_bit = data_q[next_idx[2:0] - 3'd1]; // Data goes LSB first.
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tx      <= 1'b1;
            busy    <= 1'b0;
            cnt     <= '0;
            bit_idx <= '0;
        end else if (!busy) begin
            if (start) begin
                busy    <= 1'b1;
                tx      <= 1'b0;                   // Start bit.
                cnt     <= '0;
                bit_idx <= '0;
            end
        end else if (cnt == CNT_LAST) begin
            cnt <= '0;
            if (bit_idx == IDX_STOP) begin
                busy <= 1'b0;                      // Stop bit complete.
                tx   <= 1'b1;
            end else begin
                bit_idx <= next_idx;
                tx      <= next_bit;
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            data_q <= data;
            par_q  <= ^data;                       // Makes the count of ones even.
        end
    end

endmodule
